//--- tcdm_pkg.sv
//////////////////////////////////////////////////////////////////////////////
// Memory-side constants of the word-interleaved TCDM model.
// Holds the address word layout shared by the crossbar, the banks and the
// order decode. The flat view is the byte address and the field view splits
// it into row, bank and byte offset.
//////////////////////////////////////////////////////////////////////////////

package tcdm_pkg;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = 4;
  localparam int unsigned BANK_ROWS = 64;
  localparam int unsigned ROW_W     = 6;
  localparam int unsigned BANK_W    = 2;

  // byte offset is the two low bits of a 32-bit word address
  typedef struct packed {
    logic [ADDR_W-ROW_W-BANK_W-3:0] unused;  // above the modelled memory
    logic [ROW_W-1:0]               row;     // bits 9..4
    logic [BANK_W-1:0]              bank;    // bits 3..2
    logic [1:0]                     offset;  // bits 1..0
  } tcdm_addr_fld_t;

  typedef union packed {
    logic [ADDR_W-1:0] flat;
    tcdm_addr_fld_t    fld;
  } tcdm_addr_t;

endpackage

//--- reorder_pkg.sv
//////////////////////////////////////////////////////////////////////////////
// Constants of the reordering front end.
// Channel count equals bank count, the order is the bank hit by channel 0,
// and read data comes back a fixed number of cycles after the grant.
//////////////////////////////////////////////////////////////////////////////

package reorder_pkg;

  localparam int unsigned NB_CHAN  = 4;
  localparam int unsigned ORDER_W  = 2;  // log2 of NB_CHAN

  // cycles from a granted read to r_valid
  localparam int unsigned RESP_LAT = 1;

endpackage

//--- reorder_decode.sv
//////////////////////////////////////////////////////////////////////////////
// Rotation order decode.
// The bank selected by channel 0 is the rotation order used by the crossbar
// and by the response path. The other channels must address consecutive
// words, which is checked here rather than handled.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reorder_decode (
  input  tcdm_pkg::tcdm_addr_t [reorder_pkg::NB_CHAN-1:0] add_i,
  input  logic                                            req_i,
  output logic [reorder_pkg::ORDER_W-1:0]                 order_o
);

  import reorder_pkg::*;

  assign order_o = add_i[0].fld.bank;  // channel 0 sets the rotation

  // channel i must land on bank order + i
  always_comb begin
    for (int i = 1; i < NB_CHAN; i++) begin
      if (req_i) begin
        a_chan_seq: assert final (add_i[i].fld.bank == ORDER_W'(order_o + i))
          else $error("reorder_decode: chan %0d addr %h out of sequence (order %h)",
                      i, add_i[i].flat, order_o);
      end
    end
  end

endmodule

//--- reorder_xbar.sv
//////////////////////////////////////////////////////////////////////////////
// Channel to bank crossbar.
// Channel i is routed to bank (order + i) mod NB_CHAN. The group is granted
// as a whole only when no bank it needs is stalled, so a stall never lets
// part of a group through. Read accepts feed the response path.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reorder_xbar (
  input  logic                                                req_i,
  input  logic                                                wen_i,
  input  tcdm_pkg::tcdm_addr_t [reorder_pkg::NB_CHAN-1:0]     add_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::BE_W-1:0]   be_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] data_i,
  input  logic [reorder_pkg::ORDER_W-1:0]                     order_i,
  input  logic [reorder_pkg::NB_CHAN-1:0]                     bank_stall_i,
  output logic                                                gnt_o,
  output logic                                                rd_accept_o,
  output logic [reorder_pkg::NB_CHAN-1:0]                     bank_req_o,
  output logic                                                bank_wen_o,
  output tcdm_pkg::tcdm_addr_t [reorder_pkg::NB_CHAN-1:0]     bank_add_o,
  output logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::BE_W-1:0]   bank_be_o,
  output logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] bank_wdata_o
);

  import reorder_pkg::*;

  logic [NB_CHAN-1:0][NB_CHAN-1:0] sel;   // [chan][bank], one-hot per chan
  logic                            grant;

  always_comb begin
    for (int i = 0; i < NB_CHAN; i++) begin
      for (int b = 0; b < NB_CHAN; b++) begin
        sel[i][b] = (ORDER_W'(order_i + i) == ORDER_W'(b));
      end
    end
  end

  // whole group or nothing, the group spans every bank
  assign grant       = req_i & ~|bank_stall_i;
  assign gnt_o       = grant;
  assign rd_accept_o = grant & wen_i;   // wen high means read
  assign bank_wen_o  = wen_i;           // one level for all banks

  // OR each channel onto the bank it selects
  always_comb begin
    for (int b = 0; b < NB_CHAN; b++) begin
      bank_req_o[b]      = grant;
      bank_add_o[b].flat = '0;
      bank_be_o[b]       = '0;
      bank_wdata_o[b]    = '0;
      for (int i = 0; i < NB_CHAN; i++) begin
        bank_add_o[b].flat |= sel[i][b] ? add_i[i].flat : '0;
        bank_be_o[b]       |= sel[i][b] ? be_i[i] : '0;
        bank_wdata_o[b]    |= sel[i][b] ? data_i[i] : '0;
      end
    end
  end

endmodule

//--- tcdm_banks.sv
//////////////////////////////////////////////////////////////////////////////
// Word-interleaved TCDM bank array.
// One single-port bank per channel, indexed by the row field of the address.
// Writes honour byte enables and take effect at the request edge; reads are
// registered and appear one cycle later. bank_wen_i high means read.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcdm_banks (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [reorder_pkg::NB_CHAN-1:0]                     bank_req_i,
  input  logic                                                bank_wen_i,
  input  tcdm_pkg::tcdm_addr_t [reorder_pkg::NB_CHAN-1:0]     bank_add_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::BE_W-1:0]   bank_be_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] bank_wdata_i,
  output logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] bank_rdata_o
);

  import tcdm_pkg::*;
  import reorder_pkg::*;

  for (genvar b = 0; b < NB_CHAN; b++) begin : g_bank
    logic [DATA_W-1:0] mem_q [BANK_ROWS];
    logic [DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_req_i[b] && !bank_wen_i) begin
        for (int k = 0; k < BE_W; k++) begin
          if (bank_be_i[b][k]) begin
            mem_q[bank_add_i[b].fld.row][k*(DATA_W/BE_W) +: DATA_W/BE_W] <=
              bank_wdata_i[b][k*(DATA_W/BE_W) +: DATA_W/BE_W];
          end
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q <= '0;
      end else if (bank_req_i[b] && bank_wen_i) begin
        rdata_q <= mem_q[bank_add_i[b].fld.row];  // one-cycle read
      end
    end

    assign bank_rdata_o[b] = rdata_q;

    // address must stay inside the modelled memory and on this bank
    a_addr_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_req_i[b] |-> (bank_add_i[b].fld.unused == '0 &&
                         bank_add_i[b].fld.bank == BANK_W'(b)))
      else $error("tcdm_banks: bank %0d addr %h out of range", b, bank_add_i[b].flat);
  end

endmodule

//--- reorder_resp.sv
//////////////////////////////////////////////////////////////////////////////
// Read response path.
// Registers the read accept and its order, then rotates the bank read data
// back onto the channels. r_valid is a single pulse one cycle after the
// grant; clear drops a pending response.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reorder_resp (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                clear_i,
  input  logic                                                rd_accept_i,
  input  logic [reorder_pkg::ORDER_W-1:0]                     order_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] bank_rdata_i,
  output logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] r_data_o,
  output logic                                                r_valid_o
);

  import reorder_pkg::*;

  logic               valid_q;
  logic [ORDER_W-1:0] order_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      order_q <= '0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
      order_q <= '0;
    end else begin
      valid_q <= rd_accept_i;
      if (rd_accept_i) order_q <= order_i;  // order of the read in flight
    end
  end

  assign r_valid_o = valid_q & ~clear_i;  // clear kills the pending pulse

  // reverse rotation
  always_comb begin
    for (int i = 0; i < NB_CHAN; i++) begin
      r_data_o[i] = bank_rdata_i[ORDER_W'(order_q + i)];
    end
  end

  a_rvalid_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_accept_i && !clear_i) |-> ##RESP_LAT (r_valid_o || clear_i))
    else $error("reorder_resp: missing r_valid after read accept");

  a_rvalid_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o |-> $past(rd_accept_i, RESP_LAT))
    else $error("reorder_resp: r_valid without a read accept");

endmodule

//--- reorder_sys.sv
//////////////////////////////////////////////////////////////////////////////
// Reordering TCDM front end, top level.
// One accelerator port with NB_CHAN lockstep channels reaches the
// word-interleaved bank array through decode, crossbar and response path.
// bank_stall_i stands for other masters holding a bank.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reorder_sys (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                clear_i,
  input  logic                                                req_i,
  input  logic                                                wen_i,
  input  tcdm_pkg::tcdm_addr_t [reorder_pkg::NB_CHAN-1:0]     add_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::BE_W-1:0]   be_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] data_i,
  input  logic [reorder_pkg::NB_CHAN-1:0]                     bank_stall_i,
  output logic                                                gnt_o,
  output logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] r_data_o,
  output logic                                                r_valid_o
);

  import tcdm_pkg::*;
  import reorder_pkg::*;

  logic [ORDER_W-1:0]                order;
  logic                              rd_accept;
  logic [NB_CHAN-1:0]                bank_req;
  logic                              bank_wen;
  tcdm_addr_t [NB_CHAN-1:0]          bank_add;
  logic [NB_CHAN-1:0][BE_W-1:0]      bank_be;
  logic [NB_CHAN-1:0][DATA_W-1:0]    bank_wdata;
  logic [NB_CHAN-1:0][DATA_W-1:0]    bank_rdata;

  reorder_decode u_decode (
    .add_i   (add_i),
    .req_i   (req_i),
    .order_o (order)
  );

  reorder_xbar u_xbar (
    .req_i        (req_i),
    .wen_i        (wen_i),
    .add_i        (add_i),
    .be_i         (be_i),
    .data_i       (data_i),
    .order_i      (order),
    .bank_stall_i (bank_stall_i),
    .gnt_o        (gnt_o),
    .rd_accept_o  (rd_accept),
    .bank_req_o   (bank_req),
    .bank_wen_o   (bank_wen),
    .bank_add_o   (bank_add),
    .bank_be_o    (bank_be),
    .bank_wdata_o (bank_wdata)
  );

  tcdm_banks u_banks (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank_req_i   (bank_req),
    .bank_wen_i   (bank_wen),
    .bank_add_i   (bank_add),
    .bank_be_i    (bank_be),
    .bank_wdata_i (bank_wdata),
    .bank_rdata_o (bank_rdata)
  );

  reorder_resp u_resp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .rd_accept_i  (rd_accept),
    .order_i      (order),
    .bank_rdata_i (bank_rdata),
    .r_data_o     (r_data_o),
    .r_valid_o    (r_valid_o)
  );

endmodule

//--- reorder_checker.sv
//////////////////////////////////////////////////////////////////////////////
// Response and grant checker for the reordering front end.
// Samples the DUT ports on the rising edge. It checks that a grant is given
// only when no bank is stalled, and that a read returns its data one cycle
// after the grant. It prints one line per finished test and keeps counts.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reorder_checker (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                req_i,
  input  logic                                                clear_i,
  input  logic [reorder_pkg::NB_CHAN-1:0]                     bank_stall_i,
  input  logic                                                gnt_i,
  input  logic                                                r_valid_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] r_data_i,
  input  logic [reorder_pkg::NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] exp_data_i,
  input  logic                                                exp_read_i,
  input  int                                                  test_id_i,
  output int                                                  pass_cnt_o,
  output int                                                  fail_cnt_o
);

  import tcdm_pkg::*;
  import reorder_pkg::*;

  logic                           pend_q = 1'b0;  // a granted request awaits its cycle
  logic                           pend_read_q;
  logic [NB_CHAN-1:0][DATA_W-1:0] pend_data_q;
  int                             pend_id_q;
  int                             errs [0:255];   // error count per test id

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
  end

  always @(posedge clk_i) begin : watch
    logic exp_gnt;
    if (!rst_ni) begin
      pend_q = 1'b0;
    end else begin
      // response of the request granted one cycle ago
      if (pend_q) begin
        if (r_valid_i !== pend_read_q) begin
          if (pend_read_q)
            $display("test %0d: no r_valid one cycle after the read grant", pend_id_q);
          else
            $display("test %0d: r_valid_o raised with no read pending", pend_id_q);
          errs[pend_id_q]++;
        end else if (pend_read_q) begin
          for (int ch = 0; ch < NB_CHAN; ch++) begin
            if (r_data_i[ch] !== pend_data_q[ch]) begin
              $display("error test %0d: r_data_o[%0d] = %h, expected %h",
                       pend_id_q, ch, r_data_i[ch], pend_data_q[ch]);
              errs[pend_id_q]++;
            end
          end
        end
        if (errs[pend_id_q] == 0) begin
          pass_cnt_o++;
          $display("test %0d passed", pend_id_q);
        end else begin
          fail_cnt_o++;
          $display("test %0d failed with %0d error(s)", pend_id_q, errs[pend_id_q]);
        end
        pend_q = 1'b0;
      end else if (r_valid_i) begin
        $display("r_valid_o raised with no request in flight (clear %b)", clear_i);
        fail_cnt_o++;
      end

      // the group needs every bank, so any stall blocks it
      if (req_i) begin
        exp_gnt = (bank_stall_i == '0);
        if (gnt_i !== exp_gnt) begin
          $display("error test %0d: gnt_o = %h, expected %h", test_id_i, gnt_i, exp_gnt);
          errs[test_id_i]++;
        end
        if (gnt_i) begin
          pend_q      = 1'b1;
          pend_read_q = exp_read_i;
          pend_data_q = exp_data_i;
          pend_id_q   = test_id_i;
        end
      end else if (gnt_i) begin
        $display("gnt_o raised while no request was present");
        fail_cnt_o++;
      end
    end
  end

endmodule

//--- tb_reorder_sys.sv
//////////////////////////////////////////////////////////////////////////////
// Testbench for the reordering TCDM front end.
// Loads the test table, drives one request group per line on the falling
// edge and holds it until granted. Read data and grants are compared by the
// checker, and a cycle counter ends a run that hangs.
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_reorder_sys;

  import tcdm_pkg::*;
  import reorder_pkg::*;

  localparam int RST_CYCLES = 16;
  localparam int MAX_TESTS  = 64;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           clear;
  logic                           req;
  logic                           wen;
  tcdm_addr_t [NB_CHAN-1:0]       add;
  logic [NB_CHAN-1:0][BE_W-1:0]   be;
  logic [NB_CHAN-1:0][DATA_W-1:0] data;
  logic [NB_CHAN-1:0]             bank_stall;
  logic                           gnt;
  logic [NB_CHAN-1:0][DATA_W-1:0] r_data;
  logic                           r_valid;
  logic [NB_CHAN-1:0][DATA_W-1:0] exp_data;
  logic                           exp_read;
  int                             test_id;
  int                             pass_cnt;
  int                             fail_cnt;

  // test table
  logic [7:0]                     t_op    [MAX_TESTS];
  logic [31:0]                    t_base  [MAX_TESTS];
  logic [BE_W-1:0]                t_be    [MAX_TESTS];
  logic [NB_CHAN-1:0]             t_stall [MAX_TESTS];
  int                             t_scyc  [MAX_TESTS];
  logic [NB_CHAN-1:0][DATA_W-1:0] t_data  [MAX_TESTS];
  int                             n_tests = 0;
  int                             limit   = 100000;
  int                             cycles  = 0;

  always #20 clk = ~clk;

  reorder_sys dut_i (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .req_i (req), .wen_i (wen),
    .add_i (add), .be_i (be), .data_i (data), .bank_stall_i (bank_stall),
    .gnt_o (gnt), .r_data_o (r_data), .r_valid_o (r_valid)
  );

  reorder_checker u_checker (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .clear_i (clear),
    .bank_stall_i (bank_stall), .gnt_i (gnt), .r_valid_i (r_valid),
    .r_data_i (r_data), .exp_data_i (exp_data), .exp_read_i (exp_read),
    .test_id_i (test_id), .pass_cnt_o (pass_cnt), .fail_cnt_o (fail_cnt)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run hung after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic set_idle();
    req        = 1'b0;
    wen        = 1'b1;
    add        = '0;
    be         = '0;
    data       = '0;
    bank_stall = '0;
  endtask

  task automatic drive_request(input int t);
    req = 1'b1;
    wen = (t_op[t] != "W");  // high means read
    for (int i = 0; i < NB_CHAN; i++) begin
      add[i].flat = t_base[t] + 32'(4 * i);  // consecutive words
      be[i]       = t_be[t];
      data[i]     = t_data[t][i];
    end
    bank_stall = t_stall[t];
    exp_data   = t_data[t];
    exp_read   = (t_op[t] == "R") || (t_op[t] == "B");
    test_id    = t + 1;
  endtask

  task automatic run_test(input int t);
    int gap;
    if (t_op[t] != "B") begin  // B follows the previous read directly
      gap = 1 + int'($urandom % 3);
      repeat (gap) @(negedge clk);
    end
    drive_request(t);
    if (t_scyc[t] > 0) begin
      repeat (t_scyc[t]) @(negedge clk);
      bank_stall = '0;
    end
    do @(posedge clk); while (!gnt);
    @(negedge clk);
    set_idle();
    if (t_op[t] == "C") begin
      clear = 1'b1;  // drops the pending response
      @(negedge clk);
      clear = 1'b0;
    end
  endtask

  initial begin : stim
    int          fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] base;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] d3;
    logic [3:0]  be_v;
    logic [3:0]  stall_v;
    int          scyc;
    void'($urandom(32'h9cce));
    set_idle();
    clear    = 1'b0;
    exp_data = '0;
    exp_read = 1'b0;
    test_id  = 0;
    rst_n    = 1'b0;
    fd = $fopen("reorder_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open reorder_tests.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#" && n_tests < MAX_TESTS) begin
          if ($sscanf(line, "%c %h %h %h %d %h %h %h %h", op, base, be_v, stall_v,
                      scyc, d0, d1, d2, d3) == 9) begin
            t_op[n_tests]    = op;
            t_base[n_tests]  = base;
            t_be[n_tests]    = be_v;
            t_stall[n_tests] = stall_v;
            t_scyc[n_tests]  = scyc;
            t_data[n_tests]  = {d3, d2, d1, d0};
            n_tests++;
          end
        end
      end
      $fclose(fd);
      limit = 40 * n_tests + RST_CYCLES;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      for (int t = 0; t < n_tests; t++) begin
        run_test(t);
      end
      repeat (4) @(negedge clk);  // last response drains
      $display("tests run %0d, passed %0d, failed %0d", n_tests, pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt == n_tests && n_tests > 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

//--- reorder_tests.txt
# op base be stall stall_cycles d0 d1 d2 d3 (hex, stall_cycles decimal)
# op W write, R read, B read right after the previous one, C read then clear
W 000 f 0 0 11110000 11110001 11110002 11110003
R 000 f 0 0 11110000 11110001 11110002 11110003
W 014 f 0 0 22220000 22220001 22220002 22220003
R 014 f 0 0 22220000 22220001 22220002 22220003
W 028 f 0 0 33330000 33330001 33330002 33330003
R 028 f 0 0 33330000 33330001 33330002 33330003
W 03c f 0 0 44440000 44440001 44440002 44440003
R 03c f 0 0 44440000 44440001 44440002 44440003
W 100 f 0 0 a0b0c0d0 a1b1c1d1 a2b2c2d2 a3b3c3d3
W 100 5 0 0 10203040 11213141 12223242 13233343
R 100 f 0 0 a020c040 a121c141 a222c242 a323c343
W 200 f 4 5 55550000 55550001 55550002 55550003
R 200 f 0 0 55550000 55550001 55550002 55550003
R 200 f 1 3 55550000 55550001 55550002 55550003
W 304 f 9 2 66660000 66660001 66660002 66660003
R 304 f 0 0 66660000 66660001 66660002 66660003
R 000 f 0 0 11110000 11110001 11110002 11110003
B 014 f 0 0 22220000 22220001 22220002 22220003
B 028 f 0 0 33330000 33330001 33330002 33330003
C 03c f 0 0 00000000 00000000 00000000 00000000
R 03c f 0 0 44440000 44440001 44440002 44440003

//--- flist.f
tcdm_pkg.sv
reorder_pkg.sv
reorder_decode.sv
reorder_xbar.sv
tcdm_banks.sv
reorder_resp.sv
reorder_sys.sv
reorder_checker.sv
tb_reorder_sys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the reorder testbench with Verilator, verdict from the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_reorder_sys \
  -f flist.f -o sim_reorder > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_reorder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
